//--- logic/axi_cmd_pkg.sv
package axi_cmd_pkg;

  localparam int WORD_W       = 32;
  localparam int HDR_WORDS    = 3;     // Command, count, address
  localparam int WR_BURST_MAX = 16;
  localparam int BUF_AW       = $clog2(WR_BURST_MAX);

  localparam int CFG_REGS         = 2;
  localparam int CFG_ADDR_FLAGS   = 0;
  localparam int CFG_ADDR_TIMEOUT = 1;

  localparam logic        DEF_WR_RESP = 1'b0;
  localparam logic        DEF_NACK    = 1'b0;
  localparam logic [31:0] DEF_TIMEOUT = 32'd100000000;  // One second at 100 MHz

  // Command field, bits 31 to 16 of header word 0
  localparam logic [15:0] CMD_PING  = 16'd0;
  localparam logic [15:0] CMD_WRITE = 16'd1;
  localparam logic [15:0] CMD_READ  = 16'd2;
  localparam logic [15:0] CMD_RESET = 16'd3;

  localparam int FLAG_CFG_SPACE = 0;
  localparam int FLAG_BURST     = 1;  // Low bit of the 2-bit burst type

  // Status word bits
  localparam int ST_CMPLT  = 0;
  localparam int ST_PING   = 1;
  localparam int ST_WRITE  = 2;
  localparam int ST_READ   = 3;
  localparam int ST_RESET  = 4;
  localparam int ST_CFG_WR = 5;
  localparam int ST_CFG_RD = 6;
  localparam int ST_UNREC  = 7;
  localparam int ST_BUS    = 8;  // Two bits of bresp

  // Sequencer states
  localparam logic [2:0] IDLE     = 3'd0;
  localparam logic [2:0] HEADER   = 3'd1;
  localparam logic [2:0] DISPATCH = 3'd2;
  localparam logic [2:0] DATA_IN  = 3'd3;
  localparam logic [2:0] BUS      = 3'd4;
  localparam logic [2:0] CFG_READ = 3'd5;
  localparam logic [2:0] RESPOND  = 3'd6;

  typedef enum logic [2:0] {
    KIND_PING,
    KIND_BUS_WRITE,
    KIND_CFG_WRITE,
    KIND_CFG_READ,
    KIND_RESET,
    KIND_UNREC
  } cmd_kind_e;

  // A config data word is either the flag set or the raw timeout
  typedef union packed {
    struct packed {
      logic [29:0] unused;
      logic        en_nack;
      logic        en_wr_resp;
    } flags;
    logic [31:0] timeout;
  } cfg_word_u;

endpackage

//--- logic/cmd_hdr_if.sv
interface cmd_hdr_if import axi_cmd_pkg::*; ();

  cmd_kind_e         kind;
  logic [1:0]        burst;
  logic [WORD_W-1:0] count;   // Data words that follow the header
  logic [WORD_W-1:0] addr;
  logic              valid;

  modport capture (
    output kind, burst, count, addr, valid
  );

  // Read side, for the sequencer, the config block and the AXI engine
  modport consume (
    input kind, burst, count, addr, valid
  );

endinterface

//--- logic/header_capture.sv
module header_capture import axi_cmd_pkg::*; (
  input  logic              clk,
  input  logic              w_rst,
  input  logic              i_word_stb,
  input  logic [WORD_W-1:0] i_word,
  input  logic              i_hdr_last,
  input  logic              i_hdr_clear,
  cmd_hdr_if.capture        hdr
);

  logic [WORD_W-1:0] r_word0;
  logic [WORD_W-1:0] r_word1;
  logic [15:0]       w_cmd;
  logic              w_cfg_space;
  cmd_kind_e         w_kind;

  // On the third strobe words 0 and 1 sit in the shift pair
  assign w_cmd       = r_word0[31:16];
  assign w_cfg_space = r_word0[FLAG_CFG_SPACE];

  always_comb begin
    case (w_cmd)
      CMD_PING:  w_kind = KIND_PING;
      CMD_WRITE: w_kind = w_cfg_space ? KIND_CFG_WRITE : KIND_BUS_WRITE;
      CMD_READ:  w_kind = w_cfg_space ? KIND_CFG_READ : KIND_UNREC;  // No bus reads
      CMD_RESET: w_kind = KIND_RESET;
      default:   w_kind = KIND_UNREC;
    endcase
  end

  always_ff @(posedge clk) begin
    if (i_word_stb) begin
      r_word0 <= r_word1;
      r_word1 <= i_word;
    end
    if (i_hdr_last) begin
      hdr.kind  <= w_kind;
      hdr.burst <= r_word0[FLAG_BURST +: 2];
      hdr.count <= r_word1;
      hdr.addr  <= i_word;   // Address is the word arriving now
    end
  end

  always_ff @(posedge clk) begin
    if (w_rst) begin
      hdr.valid <= 1'b0;
    end else if (i_hdr_last) begin
      hdr.valid <= 1'b1;
    end else if (i_hdr_clear) begin
      hdr.valid <= 1'b0;
    end
  end

endmodule

//--- logic/word_counter.sv
module word_counter import axi_cmd_pkg::*; (
  input  logic              clk,
  input  logic              w_rst,
  input  logic              i_clear,
  input  logic              i_step,
  input  logic [WORD_W-1:0] i_limit,
  output logic [WORD_W-1:0] o_count,
  output logic              o_last
);

  // Clear wins over a step in the same cycle
  always_ff @(posedge clk) begin
    if (w_rst || i_clear) begin
      o_count <= '0;
    end else if (i_step) begin
      o_count <= o_count + 32'd1;
    end
  end

  // Next step reaches the limit
  assign o_last = (o_count + 32'd1) == i_limit;

endmodule

//--- logic/cmd_sequencer.sv
module cmd_sequencer import axi_cmd_pkg::*; (
  input  logic              clk,
  input  logic              w_rst,
  input  logic              i_in_stb,
  cmd_hdr_if.consume        hdr,
  input  logic [WORD_W-1:0] i_cnt,
  input  logic              i_cnt_last,
  input  logic              i_wr_resp_en,
  input  logic              i_bus_done,
  output logic              o_cnt_clear,
  output logic              o_cnt_step,
  output logic [WORD_W-1:0] o_cnt_limit,
  output logic              o_hdr_last,
  output logic              o_hdr_clear,
  output logic              o_buf_push,
  output logic              o_cfg_wr,
  output logic              o_cfg_rd,
  output logic              o_cfg_reset,
  output logic              o_bus_start,
  output logic              o_status_send,
  output logic              o_out_sel_cfg,
  output logic              o_idle
);

  logic [2:0] r_state;
  logic       r_bus_start;
  logic       r_cfg_reset;
  logic       w_in_hdr;
  logic       w_hdr_stb;
  logic       w_is_write;
  logic       w_data_stb;
  logic       w_data_done;

  assign w_in_hdr   = (r_state == IDLE) || (r_state == HEADER);
  assign w_hdr_stb  = i_in_stb && w_in_hdr;
  assign w_is_write = (hdr.kind == KIND_BUS_WRITE) || (hdr.kind == KIND_CFG_WRITE);
  // Data may follow the header with no gap, so DISPATCH takes it too
  assign w_data_stb  = i_in_stb && w_is_write && ((r_state == DISPATCH) || (r_state == DATA_IN));
  assign w_data_done = w_data_stb && i_cnt_last;

  assign o_cnt_limit = w_in_hdr ? WORD_W'(HDR_WORDS) : hdr.count;
  assign o_cnt_step  = w_hdr_stb || w_data_stb || (r_state == CFG_READ);
  assign o_cnt_clear = o_hdr_last || (r_state == BUS) || (r_state == RESPOND) ||
                       ((r_state == CFG_READ) && i_cnt_last);

  assign o_hdr_last    = w_hdr_stb && i_cnt_last;
  assign o_hdr_clear   = (r_state == IDLE);
  assign o_buf_push    = w_data_stb && (hdr.kind == KIND_BUS_WRITE);
  assign o_cfg_wr      = w_data_stb && (hdr.kind == KIND_CFG_WRITE);
  assign o_cfg_rd      = (r_state == CFG_READ);
  assign o_out_sel_cfg = (r_state == CFG_READ);
  assign o_status_send = (r_state == RESPOND);
  assign o_bus_start   = r_bus_start;   // Buffer is readable one cycle after last push
  assign o_cfg_reset   = r_cfg_reset;
  assign o_idle        = (r_state == IDLE);

  always_ff @(posedge clk) begin
    if (w_rst) begin
      r_state     <= IDLE;
      r_bus_start <= 1'b0;
      r_cfg_reset <= 1'b0;
    end else begin
      r_bus_start <= w_data_done && (hdr.kind == KIND_BUS_WRITE);
      r_cfg_reset <= (r_state == DISPATCH) && (hdr.kind == KIND_RESET);
      case (r_state)
        IDLE: begin
          if (i_in_stb) r_state <= HEADER;
        end
        HEADER: begin
          if (o_hdr_last) r_state <= DISPATCH;
        end
        DISPATCH: begin
          if (w_is_write) begin
            r_state <= w_data_done ? BUS : DATA_IN;
          end else if (hdr.kind == KIND_RESET) begin
            r_state <= IDLE;  // Reset sends no status
          end else begin
            r_state <= RESPOND;
          end
        end
        DATA_IN: begin
          if (w_data_done) r_state <= BUS;
        end
        BUS: begin
          // Config writes pass straight through, flags already updated
          if ((hdr.kind == KIND_CFG_WRITE) || i_bus_done) begin
            r_state <= i_wr_resp_en ? RESPOND : IDLE;
          end
        end
        RESPOND: begin
          r_state <= (hdr.kind == KIND_CFG_READ) ? CFG_READ : IDLE;
        end
        CFG_READ: begin
          if (i_cnt_last) r_state <= IDLE;
        end
        default: r_state <= IDLE;
      endcase
    end
  end

  a_burst_count: assert property (@(posedge clk) disable iff (w_rst)
    (r_state == DISPATCH && hdr.kind == KIND_BUS_WRITE) |->
      (hdr.count >= 1 && hdr.count <= WR_BURST_MAX));

  // Counter and header agree for the whole data phase
  a_data_phase: assert property (@(posedge clk) disable iff (w_rst)
    (r_state == DATA_IN) |-> (hdr.valid && i_cnt < hdr.count));

endmodule

//--- logic/write_buffer.sv
module write_buffer import axi_cmd_pkg::*; (
  input  logic              clk,
  input  logic              w_rst,
  input  logic              i_push,
  input  logic [WORD_W-1:0] i_data,
  input  logic              i_pop,
  output logic [WORD_W-1:0] o_data,
  output logic              o_last,
  output logic              o_empty
);

  logic [WORD_W-1:0] r_mem [WR_BURST_MAX];
  logic [BUF_AW-1:0] r_wr_ptr;
  logic [BUF_AW-1:0] r_rd_ptr;
  logic [BUF_AW:0]   r_count;
  logic              w_full;

  always_ff @(posedge clk) begin
    if (i_push) r_mem[r_wr_ptr] <= i_data;
  end

  // Pointers wrap at 16
  always_ff @(posedge clk) begin
    if (w_rst) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
    end else begin
      if (i_push) r_wr_ptr <= r_wr_ptr + BUF_AW'(1);
      if (i_pop)  r_rd_ptr <= r_rd_ptr + BUF_AW'(1);
      case ({i_push, i_pop})
        2'b10:   r_count <= r_count + (BUF_AW + 1)'(1);
        2'b01:   r_count <= r_count - (BUF_AW + 1)'(1);
        default: r_count <= r_count;
      endcase
    end
  end

  assign o_data  = r_mem[r_rd_ptr];   // Head word, no read latency
  assign o_last  = (r_count == 1);
  assign o_empty = (r_count == 0);
  assign w_full  = (r_count == WR_BURST_MAX);

  a_no_overrun: assert property (@(posedge clk) disable iff (w_rst)
    !(i_push && w_full) && !(i_pop && o_empty));

endmodule

//--- logic/axi_write_engine.sv
module axi_write_engine import axi_cmd_pkg::*; (
  input  logic              clk,
  input  logic              w_rst,
  input  logic              i_start,
  cmd_hdr_if.consume        hdr,
  input  logic [WORD_W-1:0] i_buf_data,
  input  logic              i_buf_last,
  output logic              o_buf_pop,
  output logic [WORD_W-1:0] o_awaddr,
  output logic [7:0]        o_awlen,
  output logic [1:0]        o_awburst,
  output logic              o_awvalid,
  input  logic              i_awready,
  output logic [WORD_W-1:0] o_wdata,
  output logic              o_wlast,
  output logic              o_wvalid,
  input  logic              i_wready,
  input  logic [1:0]        i_bresp,
  input  logic              i_bvalid,
  output logic              o_bready,
  output logic [1:0]        o_bresp,
  output logic              o_done
);

  // Header holds steady for the whole burst
  assign o_awaddr  = hdr.addr;
  assign o_awlen   = hdr.count[7:0] - 8'd1;
  assign o_awburst = hdr.burst;

  // Data comes from the buffer head, which only moves on a beat
  assign o_wdata   = i_buf_data;
  assign o_wlast   = i_buf_last;
  assign o_buf_pop = o_wvalid && i_wready;
  assign o_done    = o_bready && i_bvalid;

  // Address, then data, then response
  always_ff @(posedge clk) begin
    if (w_rst) begin
      o_awvalid <= 1'b0;
      o_wvalid  <= 1'b0;
      o_bready  <= 1'b0;
      o_bresp   <= 2'b00;
    end else begin
      if (i_start) begin
        o_awvalid <= 1'b1;
      end else if (o_awvalid && i_awready) begin
        o_awvalid <= 1'b0;
        o_wvalid  <= 1'b1;
      end
      if (o_wvalid && i_wready && i_buf_last) begin
        o_wvalid <= 1'b0;
        o_bready <= 1'b1;
      end
      if (o_done) begin
        o_bready <= 1'b0;
        o_bresp  <= i_bresp;  // Kept for the status word
      end
    end
  end

  a_aw_hold: assert property (@(posedge clk) disable iff (w_rst)
    (o_awvalid && !i_awready) |=>
      (o_awvalid && $stable(o_awaddr) && $stable(o_awlen) && $stable(o_awburst)));

  a_w_hold: assert property (@(posedge clk) disable iff (w_rst)
    (o_wvalid && !i_wready) |=> (o_wvalid && $stable(o_wdata) && $stable(o_wlast)));

endmodule

//--- logic/master_config.sv
module master_config import axi_cmd_pkg::*; (
  input  logic              clk,
  input  logic              w_rst,
  input  logic              i_wr,
  input  logic [WORD_W-1:0] i_rd_addr_off,
  input  cfg_word_u         i_data,
  input  logic              i_reset,
  cmd_hdr_if.consume        hdr,
  input  logic [1:0]        i_bresp,
  input  logic              i_sel_cfg,
  output logic              o_wr_resp_en,
  output logic [WORD_W-1:0] o_out_data
);

  logic              r_en_nack;
  logic              r_en_wr_resp;
  logic [WORD_W-1:0] r_timeout;   // Stored only, no timer behind it
  logic [WORD_W-1:0] w_addr;
  cfg_word_u         w_rd_word;
  logic [WORD_W-1:0] w_status;

  assign w_addr = hdr.addr + i_rd_addr_off;

  always_ff @(posedge clk) begin
    if (w_rst || i_reset) begin
      r_en_nack    <= DEF_NACK;
      r_en_wr_resp <= DEF_WR_RESP;
      r_timeout    <= DEF_TIMEOUT;
    end else if (i_wr) begin
      case (w_addr)
        CFG_ADDR_FLAGS: begin
          r_en_nack    <= i_data.flags.en_nack;
          r_en_wr_resp <= i_data.flags.en_wr_resp;
        end
        CFG_ADDR_TIMEOUT: r_timeout <= i_data.timeout;
        default: begin
        end
      endcase
    end
  end

  // Reads past the register set return zero
  always_comb begin
    w_rd_word = '0;
    if (w_addr < CFG_REGS) begin
      if (w_addr == CFG_ADDR_TIMEOUT) begin
        w_rd_word.timeout = r_timeout;
      end else begin
        w_rd_word.flags.en_nack    = r_en_nack;
        w_rd_word.flags.en_wr_resp = r_en_wr_resp;
      end
    end
  end

  always_comb begin
    w_status              = '0;
    w_status[ST_CMPLT]    = 1'b1;
    w_status[ST_PING]     = (hdr.kind == KIND_PING);
    w_status[ST_WRITE]    = (hdr.kind == KIND_BUS_WRITE);
    w_status[ST_READ]     = 1'b0;   // Bus reads not supported
    w_status[ST_RESET]    = (hdr.kind == KIND_RESET);
    w_status[ST_CFG_WR]   = (hdr.kind == KIND_CFG_WRITE);
    w_status[ST_CFG_RD]   = (hdr.kind == KIND_CFG_READ);
    w_status[ST_UNREC]    = (hdr.kind == KIND_UNREC);
    w_status[ST_BUS +: 2] = i_bresp;
  end

  assign o_out_data   = i_sel_cfg ? w_rd_word : w_status;
  assign o_wr_resp_en = r_en_wr_resp;

endmodule

//--- logic/axi_master_top.sv
module axi_master_top import axi_cmd_pkg::*; (
  input  logic              clk,
  input  logic              w_rst,
  input  logic              i_in_stb,
  input  logic [WORD_W-1:0] i_in_data,
  output logic              o_out_stb,
  output logic [WORD_W-1:0] o_out_data,
  output logic              o_idle,
  output logic [WORD_W-1:0] o_awaddr,
  output logic [7:0]        o_awlen,
  output logic [1:0]        o_awburst,
  output logic              o_awvalid,
  input  logic              i_awready,
  output logic [WORD_W-1:0] o_wdata,
  output logic              o_wlast,
  output logic              o_wvalid,
  input  logic              i_wready,
  input  logic [1:0]        i_bresp,
  input  logic              i_bvalid,
  output logic              o_bready,
  output logic              o_areset_n
);

  logic [WORD_W-1:0] w_cnt;
  logic [WORD_W-1:0] w_cnt_limit;
  logic              w_cnt_last;
  logic              w_cnt_clear;
  logic              w_cnt_step;
  logic              w_hdr_last;
  logic              w_hdr_clear;
  logic              w_buf_push;
  logic              w_buf_pop;
  logic              w_buf_last;
  logic [WORD_W-1:0] w_buf_data;
  logic              w_cfg_wr;
  logic              w_cfg_rd;
  logic              w_cfg_reset;
  logic              w_bus_start;
  logic              w_bus_done;
  logic [1:0]        w_bresp;
  logic              w_status_send;
  logic              w_out_sel_cfg;
  logic              w_wr_resp_en;

  cmd_hdr_if u_hdr ();

  assign o_out_stb  = w_status_send || w_cfg_rd;  // Status, then config words
  assign o_areset_n = ~w_cfg_reset;

  header_capture u_header_capture (
    .clk         (clk),
    .w_rst       (w_rst),
    .i_word_stb  (i_in_stb),
    .i_word      (i_in_data),
    .i_hdr_last  (w_hdr_last),
    .i_hdr_clear (w_hdr_clear),
    .hdr         (u_hdr)
  );

  word_counter u_word_counter (
    .clk     (clk),
    .w_rst   (w_rst),
    .i_clear (w_cnt_clear),
    .i_step  (w_cnt_step),
    .i_limit (w_cnt_limit),
    .o_count (w_cnt),
    .o_last  (w_cnt_last)
  );

  cmd_sequencer u_cmd_sequencer (
    .clk           (clk),
    .w_rst         (w_rst),
    .i_in_stb      (i_in_stb),
    .hdr           (u_hdr),
    .i_cnt         (w_cnt),
    .i_cnt_last    (w_cnt_last),
    .i_wr_resp_en  (w_wr_resp_en),
    .i_bus_done    (w_bus_done),
    .o_cnt_clear   (w_cnt_clear),
    .o_cnt_step    (w_cnt_step),
    .o_cnt_limit   (w_cnt_limit),
    .o_hdr_last    (w_hdr_last),
    .o_hdr_clear   (w_hdr_clear),
    .o_buf_push    (w_buf_push),
    .o_cfg_wr      (w_cfg_wr),
    .o_cfg_rd      (w_cfg_rd),
    .o_cfg_reset   (w_cfg_reset),
    .o_bus_start   (w_bus_start),
    .o_status_send (w_status_send),
    .o_out_sel_cfg (w_out_sel_cfg),
    .o_idle        (o_idle)
  );

  write_buffer u_write_buffer (
    .clk     (clk),
    .w_rst   (w_rst),
    .i_push  (w_buf_push),
    .i_data  (i_in_data),
    .i_pop   (w_buf_pop),
    .o_data  (w_buf_data),
    .o_last  (w_buf_last),
    .o_empty ()
  );

  axi_write_engine u_axi_write_engine (
    .clk        (clk),
    .w_rst      (w_rst),
    .i_start    (w_bus_start),
    .hdr        (u_hdr),
    .i_buf_data (w_buf_data),
    .i_buf_last (w_buf_last),
    .o_buf_pop  (w_buf_pop),
    .o_awaddr   (o_awaddr),
    .o_awlen    (o_awlen),
    .o_awburst  (o_awburst),
    .o_awvalid  (o_awvalid),
    .i_awready  (i_awready),
    .o_wdata    (o_wdata),
    .o_wlast    (o_wlast),
    .o_wvalid   (o_wvalid),
    .i_wready   (i_wready),
    .i_bresp    (i_bresp),
    .i_bvalid   (i_bvalid),
    .o_bready   (o_bready),
    .o_bresp    (w_bresp),
    .o_done     (w_bus_done)
  );

  master_config u_master_config (
    .clk           (clk),
    .w_rst         (w_rst),
    .i_wr          (w_cfg_wr),
    .i_rd_addr_off (w_cnt),
    .i_data        (i_in_data),
    .i_reset       (w_cfg_reset),
    .hdr           (u_hdr),
    .i_bresp       (w_bresp),
    .i_sel_cfg     (w_out_sel_cfg),
    .o_wr_resp_en  (w_wr_resp_en),
    .o_out_data    (o_out_data)
  );

endmodule

//--- verif/tb_axi_master.sv
module tb_axi_master import axi_cmd_pkg::*; ();

  localparam logic [31:0] SEED         = 32'd86218;
  localparam int          PACKETS      = 200;
  localparam int          IDLE_TIMEOUT = 400;  // Cycles per packet

  logic        clk = 1'b0;
  logic        w_rst;
  logic        i_in_stb;
  logic [31:0] i_in_data;
  logic        o_out_stb;
  logic [31:0] o_out_data;
  logic        o_idle;
  logic [31:0] o_awaddr;
  logic [7:0]  o_awlen;
  logic [1:0]  o_awburst;
  logic        o_awvalid;
  logic        i_awready;
  logic [31:0] o_wdata;
  logic        o_wlast;
  logic        o_wvalid;
  logic        i_wready;
  logic [1:0]  i_bresp;
  logic        i_bvalid;
  logic        o_bready;
  logic        o_areset_n;

  // Reference model
  logic        m_nack;
  logic        m_wr_resp;
  logic [31:0] m_timeout;
  logic [1:0]  m_bresp;
  logic [31:0] exp_word [$];
  int          exp_cyc [$];   // -1 when the cycle is not fixed
  int          exp_rst_cyc;
  int          exp_c;

  // AXI slave model
  logic [31:0] exp_wdata [$];
  logic [31:0] exp_awaddr;
  logic [7:0]  exp_awlen;
  logic [1:0]  exp_awburst;
  logic [31:0] beat_word;
  logic        aw_pending;
  logic        aw_first;
  int          exp_aw_cyc;
  logic        b_wait;
  logic        b_taken;
  logic [1:0]  b_delay;
  logic [1:0]  next_bresp;

  logic [31:0] m_rng;
  logic [31:0] s_rng;
  logic        force_cfg_read;
  int          cyc = 0;
  int          last_cyc;

  axi_master_top u_dut (
    .clk        (clk),
    .w_rst      (w_rst),
    .i_in_stb   (i_in_stb),
    .i_in_data  (i_in_data),
    .o_out_stb  (o_out_stb),
    .o_out_data (o_out_data),
    .o_idle     (o_idle),
    .o_awaddr   (o_awaddr),
    .o_awlen    (o_awlen),
    .o_awburst  (o_awburst),
    .o_awvalid  (o_awvalid),
    .i_awready  (i_awready),
    .o_wdata    (o_wdata),
    .o_wlast    (o_wlast),
    .o_wvalid   (o_wvalid),
    .i_wready   (i_wready),
    .i_bresp    (i_bresp),
    .i_bvalid   (i_bvalid),
    .o_bready   (o_bready),
    .o_areset_n (o_areset_n)
  );

  always #50 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand_word();
    m_rng = xorshift(m_rng);
    return m_rng;
  endfunction

  task automatic fail_run(input string what);
    $display("error at %0t: %s", $time, what);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "stopped at first error");
    end
  endtask

  // Status word as the host should see it
  function automatic logic [31:0] status_word(input int kind_bit);
    logic [31:0] s;
    s = '0;
    s[ST_CMPLT] = 1'b1;
    s[kind_bit] = 1'b1;
    s[ST_BUS +: 2] = m_bresp;
    return s;
  endfunction

  function automatic logic [31:0] cfg_value(input logic [31:0] a);
    if (a == 32'd0) return {30'b0, m_nack, m_wr_resp};
    if (a == 32'd1) return m_timeout;
    return 32'd0;
  endfunction

  task automatic apply_cfg_write(input logic [31:0] a, input logic [31:0] d);
    if (a == 32'd0) begin
      m_nack    = d[1];
      m_wr_resp = d[0];
    end else if (a == 32'd1) begin
      m_timeout = d;
    end
  endtask

  task automatic push_word(input logic [31:0] w, input int c);
    exp_word.push_back(w);
    exp_cyc.push_back(c);
  endtask

  task automatic send_word(input logic [31:0] w);
    if (rand_word() % 4 == 0) @(negedge clk);  // Occasional gap
    i_in_stb  = 1'b1;
    i_in_data = w;
    last_cyc  = cyc;
    @(negedge clk);
    i_in_stb  = 1'b0;
  endtask

  task automatic send_header(input logic [15:0] cmd, input logic [15:0] flags,
                             input logic [31:0] cnt, input logic [31:0] addr);
    send_word({cmd, flags});
    send_word(cnt);
    send_word(addr);
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > IDLE_TIMEOUT) fail_run("timeout waiting for o_idle after a packet");
    end while (!o_idle);
  endtask

  task automatic run_packet();
    int          kind;
    int          i;
    logic        forced;
    logic [31:0] r;
    logic [31:0] addr;
    logic [31:0] cnt;
    logic [31:0] d;
    logic [15:0] cmd;
    logic [31:0] data [$];
    r      = rand_word();
    forced = force_cfg_read;
    kind   = forced ? 4 : int'(r % 7);
    force_cfg_read = 1'b0;
    case (kind)
      0: begin
        send_header(CMD_PING, r[31:16], 32'd1, rand_word());
        push_word(status_word(ST_PING), last_cyc + 2);
      end
      1, 2: begin  // Bus write with the slave model checking the beats
        cnt         = (rand_word() % 16) + 32'd1;
        exp_awaddr  = rand_word() & ~32'h3;
        exp_awlen   = 8'(cnt - 32'd1);
        exp_awburst = {1'b0, r[20]};
        next_bresp  = r[25:24];
        m_bresp     = r[25:24];
        for (i = 0; i < int'(cnt); i++) begin
          d = rand_word();
          data.push_back(d);
          exp_wdata.push_back(d);
        end
        aw_pending = 1'b1;
        send_header(CMD_WRITE, {r[15:3], exp_awburst, 1'b0}, cnt, exp_awaddr);
        foreach (data[k]) send_word(data[k]);
        exp_aw_cyc = last_cyc + 2;
        aw_first   = 1'b1;
        if (m_wr_resp) push_word(status_word(ST_WRITE), -1);
      end
      3: begin
        addr = rand_word() % 3;
        cnt  = (rand_word() % 4) + 32'd1;
        send_header(CMD_WRITE, r[15:0] | 16'h0001, cnt, addr);
        for (i = 0; i < int'(cnt); i++) begin
          d = rand_word();
          apply_cfg_write(addr + 32'(i), d);
          send_word(d);
        end
        if (m_wr_resp) push_word(status_word(ST_CFG_WR), last_cyc + 2);
      end
      4: begin
        addr = forced ? 32'd0 : rand_word() % 3;
        cnt  = forced ? 32'd3 : (rand_word() % 4) + 32'd1;
        send_header(CMD_READ, r[15:0] | 16'h0001, cnt, addr);
        if (forced) check_value("reset pulse seen", 32'(exp_rst_cyc), 32'hffff_ffff);
        push_word(status_word(ST_CFG_RD), last_cyc + 2);
        for (i = 0; i < int'(cnt); i++) push_word(cfg_value(addr + 32'(i)), last_cyc + 3 + i);
      end
      5: begin  // Unknown code, or a bus read
        cmd = (r[31:16] < 16'd4) ? r[31:16] + 16'd4 : r[31:16];
        if (r[0]) send_header(CMD_READ, r[15:0] & 16'hfffe, 32'd1, rand_word());
        else send_header(cmd, r[15:0], 32'd1, rand_word());
        push_word(status_word(ST_UNREC), last_cyc + 2);
      end
      default: begin
        send_header(CMD_RESET, r[15:0], 32'd1, rand_word());
        exp_rst_cyc    = last_cyc + 2;
        m_nack         = DEF_NACK;
        m_wr_resp      = DEF_WR_RESP;
        m_timeout      = DEF_TIMEOUT;
        force_cfg_read = 1'b1;
      end
    endcase
  endtask

  // Host output monitor and AXI slave
  always @(negedge clk) begin
    if (o_out_stb) begin
      if (exp_word.size() == 0) begin
        fail_run("output strobe while no word was expected");
      end else begin
        check_value("output word", o_out_data, exp_word.pop_front());
        exp_c = exp_cyc.pop_front();
        if (exp_c >= 0) check_value("output word cycle", 32'(cyc), 32'(exp_c));
      end
    end
    if (!o_areset_n) begin
      check_value("o_areset_n low cycle", 32'(cyc), 32'(exp_rst_cyc));
      exp_rst_cyc = -1;
    end

    if (b_taken) begin
      i_bvalid = 1'b0;
      b_taken  = 1'b0;
    end else if (b_wait) begin
      if (b_delay == 2'd0) begin
        i_bvalid = 1'b1;
        i_bresp  = next_bresp;
        b_wait   = 1'b0;
      end else begin
        b_delay = b_delay - 2'd1;
      end
    end
    s_rng     = xorshift(s_rng);
    i_awready = s_rng[0] | s_rng[1];
    i_wready  = s_rng[2] | s_rng[3];

    if (o_awvalid && !aw_pending) fail_run("address valid with no bus write pending");
    if (o_awvalid && aw_first) begin
      check_value("awvalid rise cycle", 32'(cyc), 32'(exp_aw_cyc));
      aw_first = 1'b0;
    end
    if (o_awvalid && i_awready) begin
      check_value("awaddr", o_awaddr, exp_awaddr);
      check_value("awlen", {24'b0, o_awlen}, {24'b0, exp_awlen});
      check_value("awburst", {30'b0, o_awburst}, {30'b0, exp_awburst});
      aw_pending = 1'b0;
    end
    if (o_wvalid && i_wready) begin
      if (exp_wdata.size() == 0) begin
        fail_run("data beat with no data pending");
      end else begin
        beat_word = exp_wdata.pop_front();
        check_value("wdata", o_wdata, beat_word);
        check_value("wlast", {31'b0, o_wlast}, {31'b0, exp_wdata.size() == 0});
        if (exp_wdata.size() == 0) begin
          b_wait  = 1'b1;
          b_delay = s_rng[5:4];
        end
      end
    end
    if (i_bvalid) begin
      check_value("o_bready while i_bvalid high", {31'b0, o_bready}, 32'd1);
      b_taken = 1'b1;
    end
  end

  initial begin
    int pkt;
    w_rst          = 1'b1;
    i_in_stb       = 1'b0;
    i_in_data      = '0;
    i_awready      = 1'b0;
    i_wready       = 1'b0;
    i_bresp        = 2'b00;
    i_bvalid       = 1'b0;
    m_nack         = DEF_NACK;
    m_wr_resp      = DEF_WR_RESP;
    m_timeout      = DEF_TIMEOUT;
    m_bresp        = 2'b00;
    exp_rst_cyc    = -1;
    aw_pending     = 1'b0;
    aw_first       = 1'b0;
    b_wait         = 1'b0;
    b_taken        = 1'b0;
    b_delay        = 2'd0;
    next_bresp     = 2'b00;
    m_rng          = SEED;
    s_rng          = SEED ^ 32'hffff_ffff;  // Separate stream for the slave
    force_cfg_read = 1'b1;                  // First packet reads the defaults
    repeat (4) @(negedge clk);
    w_rst = 1'b0;
    check_value("o_idle after reset", {31'b0, o_idle}, 32'd1);
    check_value("o_out_stb after reset", {31'b0, o_out_stb}, 32'd0);
    check_value("o_awvalid after reset", {31'b0, o_awvalid}, 32'd0);
    check_value("o_wvalid after reset", {31'b0, o_wvalid}, 32'd0);
    check_value("o_bready after reset", {31'b0, o_bready}, 32'd0);
    check_value("o_areset_n after reset", {31'b0, o_areset_n}, 32'd1);

    for (pkt = 0; pkt < PACKETS; pkt++) begin
      run_packet();
      wait_idle();
      check_value("output words still expected", 32'(exp_word.size()), 32'd0);
      check_value("data beats still expected", 32'(exp_wdata.size()), 32'd0);
      check_value("address beat still expected", {31'b0, aw_pending}, 32'd0);
    end
    repeat (3) @(negedge clk);
    check_value("reset pulse seen", 32'(exp_rst_cyc), 32'hffff_ffff);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- filelist.f
logic/axi_cmd_pkg.sv
logic/cmd_hdr_if.sv
logic/header_capture.sv
logic/word_counter.sv
logic/cmd_sequencer.sv
logic/write_buffer.sv
logic/axi_write_engine.sv
logic/master_config.sv
logic/axi_master_top.sv
verif/tb_axi_master.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then search the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_axi_master \
  -f filelist.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || echo "build or simulation ended with an error"
grep -qsx "ALL CHECKS PASSED" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
